// ==== sources.f ====
+incdir+common
common/ecc_pkg.sv
ecc_core/ecc_77_cal.sv
ecc_core/ecc_read_stage.sv
rtl/ecc_write_stage.sv
rtl/ecc_array.sv
rtl/ecc_err_status.sv
rtl/ecc_mem_top.sv
verif/tb_clkgen.sv
verif/ecc_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ECC memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module ecc_mem_tb \
    -Mdir obj_dir -o ecc_mem_sim

./obj_dir/ecc_mem_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== verif/ecc_mem_tb.sv ====
`timescale 1ns/1ns
`include "ecc_settings.svh"

module ecc_mem_tb;

    localparam int CW_WIDTH = `DATA_WIDTH + `PARITY_WIDTH;

    logic                   clk;
    logic                   reset;
    logic                   wr_en;
    logic [`ADDR_WIDTH-1:0] wr_addr;
    logic [`DATA_WIDTH-1:0] wr_data;
    logic [CW_WIDTH-1:0]    inj_mask;
    logic                   rd_en;
    logic [`ADDR_WIDTH-1:0] rd_addr;
    logic                   bypass;
    logic                   clr_cnt;
    logic                   rd_valid;
    logic [`DATA_WIDTH-1:0] rd_data;
    logic                   rd_sbit_err;
    logic                   rd_dbit_err;
    logic [`CNT_WIDTH-1:0]  sbit_cnt;
    logic [`CNT_WIDTH-1:0]  dbit_cnt;
    logic [`ADDR_WIDTH-1:0] last_err_addr;

    // Model of what each address holds
    logic [`DATA_WIDTH-1:0] model_data [`MEM_DEPTH];
    logic [`DATA_WIDTH-1:0] model_stored [`MEM_DEPTH];   // Data field after injection
    int                     model_flips [`MEM_DEPTH];

    // Expected result of the read being issued, then two pipeline stages
    logic [`DATA_WIDTH-1:0] iss_data, p1_data, p2_data;
    logic [`ADDR_WIDTH-1:0] iss_addr, p1_addr, p2_addr;
    logic                   iss_sbit, p1_sbit, p2_sbit;
    logic                   iss_dbit, p1_dbit, p2_dbit;
    logic                   iss_chk, p1_chk, p2_chk;
    logic                   p1_valid, p2_valid;

    logic [`CNT_WIDTH-1:0]  tally_sbit;
    logic [`CNT_WIDTH-1:0]  tally_dbit;
    logic [`ADDR_WIDTH-1:0] tally_addr;

    integer seed;
    int     err_cnt;
    int     err_mark;
    int     pass_tests;
    int     fail_tests;
    int     issued_cnt;
    int     returned_cnt;

    tb_clkgen u_clkgen (.clk(clk), .reset(reset));

    ecc_mem_top u_dut (
        .clk(clk), .reset(reset), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .inj_mask(inj_mask), .rd_en(rd_en), .rd_addr(rd_addr), .bypass(bypass),
        .clr_cnt(clr_cnt), .rd_valid(rd_valid), .rd_data(rd_data),
        .rd_sbit_err(rd_sbit_err), .rd_dbit_err(rd_dbit_err), .sbit_cnt(sbit_cnt),
        .dbit_cnt(dbit_cnt), .last_err_addr(last_err_addr)
    );

    // Read latency is two edges, same as the DUT
    always @(posedge clk) begin
        if (reset) begin
            p1_valid <= 1'b0;
            p2_valid <= 1'b0;
        end else begin
            p1_valid <= rd_en;
            p2_valid <= p1_valid;
        end
        {p1_data, p1_addr, p1_sbit, p1_dbit, p1_chk} <=
            {iss_data, iss_addr, iss_sbit, iss_dbit, iss_chk};
        {p2_data, p2_addr, p2_sbit, p2_dbit, p2_chk} <=
            {p1_data, p1_addr, p1_sbit, p1_dbit, p1_chk};
    end

    always @(posedge clk) begin
        if (reset || clr_cnt) begin
            tally_sbit <= '0;
            tally_dbit <= '0;
            tally_addr <= '0;
        end else if (p2_valid) begin
            if (p2_sbit && !(&tally_sbit)) tally_sbit <= tally_sbit + 16'd1;
            if (p2_dbit && !(&tally_dbit)) tally_dbit <= tally_dbit + 16'd1;
            if (p2_sbit || p2_dbit) tally_addr <= p2_addr;
        end
        if (!reset && rd_valid) returned_cnt <= returned_cnt + 1;
    end

    a_valid_timing: assert property (@(posedge clk) disable iff (reset) rd_valid == p2_valid)
        else begin
            $display("ERROR rd_valid expected %h actual %h", $sampled(p2_valid),
                     $sampled(rd_valid));
            err_cnt++;
        end

    a_data: assert property (@(posedge clk) disable iff (reset)
        p2_valid && p2_chk |-> rd_data == p2_data)
        else begin
            $display("ERROR rd_data expected %h actual %h", $sampled(p2_data),
                     $sampled(rd_data));
            err_cnt++;
        end

    a_sbit: assert property (@(posedge clk) disable iff (reset)
        p2_valid |-> rd_sbit_err == p2_sbit)
        else begin
            $display("ERROR rd_sbit_err expected %h actual %h", $sampled(p2_sbit),
                     $sampled(rd_sbit_err));
            err_cnt++;
        end

    a_dbit: assert property (@(posedge clk) disable iff (reset)
        p2_valid |-> rd_dbit_err == p2_dbit)
        else begin
            $display("ERROR rd_dbit_err expected %h actual %h", $sampled(p2_dbit),
                     $sampled(rd_dbit_err));
            err_cnt++;
        end

    a_sbit_cnt: assert property (@(posedge clk) disable iff (reset) sbit_cnt == tally_sbit)
        else begin
            $display("ERROR sbit_cnt expected %h actual %h", $sampled(tally_sbit),
                     $sampled(sbit_cnt));
            err_cnt++;
        end

    a_dbit_cnt: assert property (@(posedge clk) disable iff (reset) dbit_cnt == tally_dbit)
        else begin
            $display("ERROR dbit_cnt expected %h actual %h", $sampled(tally_dbit),
                     $sampled(dbit_cnt));
            err_cnt++;
        end

    a_last_addr: assert property (@(posedge clk) disable iff (reset)
        last_err_addr == tally_addr)
        else begin
            $display("ERROR last_err_addr expected %h actual %h", $sampled(tally_addr),
                     $sampled(last_err_addr));
            err_cnt++;
        end

    a_clear: assert property (@(posedge clk) disable iff (reset)
        clr_cnt |=> sbit_cnt == '0 && dbit_cnt == '0 && last_err_addr == '0)
        else begin
            $display("Status was not cleared one cycle after clr_cnt");
            err_cnt++;
        end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] rand_data();
        logic [95:0] r;

        r = {$random(seed), $random(seed), $random(seed)};
        return r[`DATA_WIDTH-1:0];
    endfunction

    function automatic logic [CW_WIDTH-1:0] bit_mask(input int pos);
        logic [CW_WIDTH-1:0] m;

        m      = '0;
        m[pos] = 1'b1;
        return m;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic write_word(input logic [`ADDR_WIDTH-1:0] addr,
                              input logic [`DATA_WIDTH-1:0] data,
                              input logic [CW_WIDTH-1:0] mask);
        wr_en                = 1'b1;
        wr_addr              = addr;
        wr_data              = data;
        inj_mask             = mask;
        model_data[addr]     = data;
        model_stored[addr]   = data ^ mask[`DATA_WIDTH-1:0];
        model_flips[addr]    = $countones(mask);
        @(negedge clk);
        wr_en    = 1'b0;
        inj_mask = '0;
        @(negedge clk);     // Array holds the word before any read is sampled
    endtask

    task automatic issue_read(input logic [`ADDR_WIDTH-1:0] addr);
        rd_en    = 1'b1;
        rd_addr  = addr;
        iss_addr = addr;
        iss_sbit = 1'b0;
        iss_dbit = 1'b0;
        iss_chk  = 1'b1;
        iss_data = model_data[addr];
        if (bypass) begin
            iss_data = model_stored[addr];
        end else if (model_flips[addr] == 1) begin
            iss_sbit = 1'b1;
        end else if (model_flips[addr] >= 2) begin
            iss_dbit = 1'b1;
            iss_chk  = 1'b0;    // Data is unspecified on a double error
        end
        issued_cnt++;
        @(negedge clk);
        rd_en = 1'b0;
    endtask

    task automatic wait_reads();
        for (int i = 0; i < 20 && returned_cnt != issued_cnt; i++) @(negedge clk);
        if (returned_cnt != issued_cnt) stop_on_timeout("rd_valid");
    endtask

    task automatic end_test(input string name);
        @(negedge clk);     // Let the status checks see the last update
        if (err_cnt == err_mark) begin
            pass_tests++;
            $display("PASS %s", name);
        end else begin
            fail_tests++;
            $display("FAIL %s", name);
        end
        err_mark = err_cnt;
    endtask

    task automatic run_clean_test();
        logic [`ADDR_WIDTH-1:0] addrs [8];

        for (int i = 0; i < 8; i++) begin
            addrs[i] = `ADDR_WIDTH'($random(seed));
            write_word(addrs[i], rand_data(), '0);
        end
        for (int i = 0; i < 8; i++) issue_read(addrs[i]);   // Back to back
        wait_reads();
        end_test("clean write and read");
    endtask

    task automatic run_flip_test(input int flips, input int tries, input string name);
        logic [`ADDR_WIDTH-1:0] addr;
        int                     a;
        int                     b;

        for (int i = 0; i < tries; i++) begin
            addr = `ADDR_WIDTH'($random(seed));
            a = (i % 2 == 0 || bypass) ? rand_below(`DATA_WIDTH)
                                       : `DATA_WIDTH + rand_below(`PARITY_WIDTH);
            b = (a + 1 + rand_below(CW_WIDTH - 1)) % CW_WIDTH;
            write_word(addr, rand_data(), flips == 2 ? bit_mask(a) | bit_mask(b) : bit_mask(a));
            issue_read(addr);
            wait_reads();
        end
        end_test(name);
    endtask

    initial begin
        seed         = 95;
        err_cnt      = 0;
        err_mark     = 0;
        pass_tests   = 0;
        fail_tests   = 0;
        issued_cnt   = 0;
        returned_cnt = 0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        inj_mask     = '0;
        rd_en        = 1'b0;
        rd_addr      = '0;
        bypass       = 1'b0;
        clr_cnt      = 1'b0;
        {iss_data, iss_addr, iss_sbit, iss_dbit, iss_chk} = '0;

        @(negedge clk);     // Clock generator raises reset at time 0
        for (int i = 0; i < 40 && reset; i++) @(negedge clk);
        if (reset) stop_on_timeout("reset release");

        run_clean_test();
        run_flip_test(1, 8, "single flip corrected");
        run_flip_test(2, 6, "double flip detected");
        bypass = 1'b1;
        run_flip_test(1, 4, "bypass returns stored data");
        bypass = 1'b0;

        clr_cnt = 1'b1;
        @(negedge clk);
        clr_cnt = 1'b0;
        run_flip_test(1, 2, "counters cleared and counting");

        $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
        if (err_cnt == 0 && fail_tests == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;   // Released on a falling edge after 10 rising edges
    end

    always #2 clk = ~clk;

endmodule

// ==== rtl/ecc_mem_top.sv ====
`timescale 1ns/1ns
`include "ecc_settings.svh"

module ecc_mem_top
    import ecc_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wr_en,
    input  logic [`ADDR_WIDTH-1:0]       wr_addr,
    input  logic [`DATA_WIDTH-1:0]       wr_data,
    input  logic [$bits(codeword_t)-1:0] inj_mask,
    input  logic                         rd_en,
    input  logic [`ADDR_WIDTH-1:0]       rd_addr,
    input  logic                         bypass,
    input  logic                         clr_cnt,
    output logic                         rd_valid,
    output logic [`DATA_WIDTH-1:0]       rd_data,
    output logic                         rd_sbit_err,
    output logic                         rd_dbit_err,
    output logic [`CNT_WIDTH-1:0]        sbit_cnt,
    output logic [`CNT_WIDTH-1:0]        dbit_cnt,
    output logic [`ADDR_WIDTH-1:0]       last_err_addr
);

    // Write stage to array
    logic                   mem_we;
    logic [`ADDR_WIDTH-1:0] mem_addr;
    codeword_t              mem_word;

    // Array to read stage
    logic                   fetch_valid;
    logic [`ADDR_WIDTH-1:0] fetch_addr;
    codeword_t              fetch_word;

    logic [`ADDR_WIDTH-1:0] rd_addr_out;  // Address of the word on rd_data

    // Port names line up across the stages
    ecc_write_stage u_write_stage (.*);

    ecc_array u_array (.*);

    ecc_read_stage u_read_stage (.*);

    ecc_err_status u_err_status (.*);

endmodule

// ==== rtl/ecc_err_status.sv ====
`timescale 1ns/1ns
`include "ecc_settings.svh"

module ecc_err_status (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clr_cnt,
    input  logic                   rd_valid,
    input  logic [`ADDR_WIDTH-1:0] rd_addr_out,
    input  logic                   rd_sbit_err,
    input  logic                   rd_dbit_err,
    output logic [`CNT_WIDTH-1:0]  sbit_cnt,
    output logic [`CNT_WIDTH-1:0]  dbit_cnt,
    output logic [`ADDR_WIDTH-1:0] last_err_addr
);

    logic sbit_sat;
    logic dbit_sat;

    assign sbit_sat = &sbit_cnt;
    assign dbit_sat = &dbit_cnt;

    always_ff @(posedge clk) begin
        if (reset || clr_cnt) begin
            sbit_cnt      <= '0;
            dbit_cnt      <= '0;
            last_err_addr <= '0;
        end else if (rd_valid) begin
            if (rd_sbit_err && !sbit_sat) sbit_cnt <= sbit_cnt + 1'b1;
            if (rd_dbit_err && !dbit_sat) dbit_cnt <= dbit_cnt + 1'b1;
            if (rd_sbit_err || rd_dbit_err) begin
                last_err_addr <= rd_addr_out;   // Most recent faulty read
            end
        end
    end

    // Saturated counters hold until cleared
    a_sbit_no_wrap: assert property (@(posedge clk) disable iff (reset)
        sbit_sat && !clr_cnt |=> sbit_sat);

    a_dbit_no_wrap: assert property (@(posedge clk) disable iff (reset)
        dbit_sat && !clr_cnt |=> dbit_sat);

endmodule

// ==== rtl/ecc_array.sv ====
`timescale 1ns/1ns
`include "ecc_settings.svh"

module ecc_array
    import ecc_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mem_we,
    input  logic [`ADDR_WIDTH-1:0] mem_addr,
    input  codeword_t              mem_word,
    input  logic                   rd_en,
    input  logic [`ADDR_WIDTH-1:0] rd_addr,
    output logic                   fetch_valid,
    output logic [`ADDR_WIDTH-1:0] fetch_addr,
    output codeword_t              fetch_word
);

    codeword_t mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem_we) mem[mem_addr] <= mem_word;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            fetch_word <= mem[rd_addr];
            fetch_addr <= rd_addr;     // Tag travels with the word
        end
    end

endmodule

// ==== rtl/ecc_write_stage.sv ====
`timescale 1ns/1ns
`include "ecc_settings.svh"

module ecc_write_stage
    import ecc_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  logic [`ADDR_WIDTH-1:0]        wr_addr,
    input  logic [`DATA_WIDTH-1:0]        wr_data,
    input  logic [$bits(codeword_t)-1:0]  inj_mask,
    output logic                          mem_we,
    output logic [`ADDR_WIDTH-1:0]        mem_addr,
    output codeword_t                     mem_word
);

    codeword_t clean_word;

    always_comb begin
        clean_word.fields.data   = wr_data;
        clean_word.fields.parity = ecc_encode(wr_data);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_we <= 1'b0;
        end else begin
            mem_we <= wr_en;
        end
    end

    // Test flips land on the flat view, data or check bits alike
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_addr     <= wr_addr;
            mem_word.raw <= clean_word.raw ^ inj_mask;
        end
    end

    a_wr_addr_known: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown(wr_addr));

endmodule

// ==== ecc_core/ecc_read_stage.sv ====
`timescale 1ns/1ns
`include "ecc_settings.svh"

module ecc_read_stage
    import ecc_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch_valid,
    input  logic [`ADDR_WIDTH-1:0] fetch_addr,
    input  codeword_t              fetch_word,
    input  logic                   bypass,
    output logic                   rd_valid,
    output logic [`ADDR_WIDTH-1:0] rd_addr_out,
    output logic [`DATA_WIDTH-1:0] rd_data,
    output logic                   rd_sbit_err,
    output logic                   rd_dbit_err
);

    logic [`DATA_WIDTH-1:0] fixed_data;
    logic                   sbit;
    logic                   dbit;

    ecc_77_cal u_cal (
        .data_in    (fetch_word.fields.data),
        .parity_in  (fetch_word.fields.parity),
        .data_out   (fixed_data),
        .parity_out (),
        .mask       (),
        .bypass     (bypass),
        .sbit_err   (sbit),
        .dbit_err   (dbit)
    );

    // Flags only pulse alongside rd_valid
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid    <= 1'b0;
            rd_sbit_err <= 1'b0;
            rd_dbit_err <= 1'b0;
        end else begin
            rd_valid    <= fetch_valid;
            rd_sbit_err <= fetch_valid & sbit;
            rd_dbit_err <= fetch_valid & dbit;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            rd_data     <= fixed_data;
            rd_addr_out <= fetch_addr;
        end
    end

    a_flags_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(rd_sbit_err && rd_dbit_err));

endmodule

// ==== ecc_core/ecc_77_cal.sv ====
`timescale 1ns/1ns
`include "ecc_settings.svh"

module ecc_77_cal
    import ecc_pkg::*;
(
    input  logic [`DATA_WIDTH-1:0]   data_in,
    input  logic [`PARITY_WIDTH-1:0] parity_in,
    output logic [`DATA_WIDTH-1:0]   data_out,
    output logic [`PARITY_WIDTH-1:0] parity_out,
    output logic [`DATA_WIDTH-1:0]   mask,
    input  logic                     bypass,
    output logic                     sbit_err,
    output logic                     dbit_err
);

    logic [`PARITY_WIDTH-1:0] syndrome;
    logic [1:0]               error;    // bit 0 single, bit 1 double

    assign parity_out = ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;
    assign data_out   = bypass ? data_in : data_in ^ mask;
    assign sbit_err   = ~bypass & error[0];
    assign dbit_err   = ~bypass & error[1];

    // Syndrome equals the column of the flipped bit
    always_comb begin
        mask  = '0;
        error = 2'b01;
        case (syndrome)
            8'b00000000 : error = 2'b00;
            8'b10000011 : mask[0]  = 1'b1;
            8'b10000101 : mask[1]  = 1'b1;
            8'b10000110 : mask[2]  = 1'b1;
            8'b00000111 : mask[3]  = 1'b1;
            8'b10001001 : mask[4]  = 1'b1;
            8'b10001010 : mask[5]  = 1'b1;
            8'b00001011 : mask[6]  = 1'b1;
            8'b10001100 : mask[7]  = 1'b1;
            8'b00001101 : mask[8]  = 1'b1;
            8'b00001110 : mask[9]  = 1'b1;
            8'b10001111 : mask[10] = 1'b1;
            8'b10010001 : mask[11] = 1'b1;
            8'b10010010 : mask[12] = 1'b1;
            8'b00010011 : mask[13] = 1'b1;
            8'b10010100 : mask[14] = 1'b1;
            8'b00010101 : mask[15] = 1'b1;
            8'b00010110 : mask[16] = 1'b1;
            8'b10010111 : mask[17] = 1'b1;
            8'b10011000 : mask[18] = 1'b1;
            8'b00011001 : mask[19] = 1'b1;
            8'b00011010 : mask[20] = 1'b1;
            8'b10011011 : mask[21] = 1'b1;
            8'b00011100 : mask[22] = 1'b1;
            8'b10011101 : mask[23] = 1'b1;
            8'b10011110 : mask[24] = 1'b1;
            8'b00011111 : mask[25] = 1'b1;
            8'b10100001 : mask[26] = 1'b1;
            8'b10100010 : mask[27] = 1'b1;
            8'b00100011 : mask[28] = 1'b1;
            8'b10100100 : mask[29] = 1'b1;
            8'b00100101 : mask[30] = 1'b1;
            8'b00100110 : mask[31] = 1'b1;
            8'b10100111 : mask[32] = 1'b1;
            8'b10101000 : mask[33] = 1'b1;
            8'b00101001 : mask[34] = 1'b1;
            8'b00101010 : mask[35] = 1'b1;
            8'b10101011 : mask[36] = 1'b1;
            8'b00101100 : mask[37] = 1'b1;
            8'b10101101 : mask[38] = 1'b1;
            8'b10101110 : mask[39] = 1'b1;
            8'b00101111 : mask[40] = 1'b1;
            8'b10110000 : mask[41] = 1'b1;
            8'b00110001 : mask[42] = 1'b1;
            8'b00110010 : mask[43] = 1'b1;
            8'b10110011 : mask[44] = 1'b1;
            8'b00110100 : mask[45] = 1'b1;
            8'b10110101 : mask[46] = 1'b1;
            8'b10110110 : mask[47] = 1'b1;
            8'b00110111 : mask[48] = 1'b1;
            8'b00111000 : mask[49] = 1'b1;
            8'b10111001 : mask[50] = 1'b1;
            8'b10111010 : mask[51] = 1'b1;
            8'b00111011 : mask[52] = 1'b1;
            8'b10111100 : mask[53] = 1'b1;
            8'b00111101 : mask[54] = 1'b1;
            8'b00111110 : mask[55] = 1'b1;
            8'b10111111 : mask[56] = 1'b1;
            8'b11000001 : mask[57] = 1'b1;
            8'b11000010 : mask[58] = 1'b1;
            8'b01000011 : mask[59] = 1'b1;
            8'b11000100 : mask[60] = 1'b1;
            8'b01000101 : mask[61] = 1'b1;
            8'b01000110 : mask[62] = 1'b1;
            8'b11000111 : mask[63] = 1'b1;
            8'b11001000 : mask[64] = 1'b1;
            8'b01001001 : mask[65] = 1'b1;
            8'b01001010 : mask[66] = 1'b1;
            8'b11001011 : mask[67] = 1'b1;
            8'b01001100 : mask[68] = 1'b1;
            8'b11001101 : mask[69] = 1'b1;
            8'b11001110 : mask[70] = 1'b1;
            8'b01001111 : mask[71] = 1'b1;
            8'b11010000 : mask[72] = 1'b1;
            8'b01010001 : mask[73] = 1'b1;
            8'b01010010 : mask[74] = 1'b1;
            8'b11010011 : mask[75] = 1'b1;
            8'b01010100 : mask[76] = 1'b1;
            // Flipped check bit, data needs no fix
            8'b10000000, 8'b01000000, 8'b00100000, 8'b00010000,
            8'b00001000, 8'b00000100, 8'b00000010, 8'b00000001 : error = 2'b01;
            default : error = 2'b10;    // Even weight or unused column
        endcase
    end

endmodule

// ==== common/ecc_pkg.sv ====
`include "ecc_settings.svh"

package ecc_pkg;

    typedef struct packed {
        logic [`PARITY_WIDTH-1:0] parity;   // Check bits sit above the data
        logic [`DATA_WIDTH-1:0]   data;
    } codeword_fields_t;

    // Stored word, seen as fields or as one flat vector for bit flips
    typedef union packed {
        codeword_fields_t                     fields;
        logic [`DATA_WIDTH+`PARITY_WIDTH-1:0] raw;
    } codeword_t;

    // Data bits covered by each check bit
    // Check bit 7 makes every data column odd weight
    localparam logic [`DATA_WIDTH-1:0] PARITY_MASK [0:`PARITY_WIDTH-1] = '{
        77'h0AAAA_B5555_5556A_AAD5B,
        77'h0CCCC_D9999_999B3_3366D,
        77'h10F0F_1E1E1_E1E3C_3C78E,
        77'h00FF0_1FE01_FE03F_C07F0,
        77'h1F000_1FFFE_0003F_FF800,
        77'h00000_1FFFF_FFFC0_00000,
        77'h1FFFF_E0000_00000_00000,
        77'h09699_72CD2_D32DA_65CB7
    };

    function automatic logic [`PARITY_WIDTH-1:0] ecc_encode(
        input logic [`DATA_WIDTH-1:0] d
    );
        logic [`PARITY_WIDTH-1:0] p;

        for (int j = 0; j < `PARITY_WIDTH; j++) begin
            p[j] = ^(d & PARITY_MASK[j]);
        end
        return p;
    endfunction

endpackage

// ==== common/ecc_settings.svh ====
`ifndef ECC_SETTINGS_SVH
`define ECC_SETTINGS_SVH

// Payload and check bits of one stored word
`define DATA_WIDTH   77
`define PARITY_WIDTH 8

`define ADDR_WIDTH   6
`define MEM_DEPTH    64
`define CNT_WIDTH    16

`endif
